// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_digital_macro -o tb_digital_macro
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_digital_macro 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: src/digital_macro.sv
// --------------------------------------------------
// digital macro
// annealer compute loop: flip manager, request
// stage, energy monitor, result stage
// --------------------------------------------------
`timescale 1ns/10ps

module digital_macro #(
    parameter int PARALLELISM     = 4,
    parameter int FLIP_ICON_DEPTH = 64,
    localparam int NUM_GROUP      = ising_pkg::NUM_SPIN / PARALLELISM,
    localparam int GROUP_BIT      = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1,
    localparam int ICON_ADDR_BIT  = $clog2(FLIP_ICON_DEPTH) + 1
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                config_valid_i,
    input  ising_pkg::spin_t                    config_spin_i,
    input  logic                                cmpt_en_i,
    input  logic                                en_comparison_i,
    output logic                                cmpt_idle_o,
    output logic                                flip_ren_o,
    output logic [ICON_ADDR_BIT-1:0]            flip_raddr_o,
    input  logic [ICON_ADDR_BIT-1:0]            icon_last_raddr_plus_one_i,
    input  ising_pkg::spin_t                    flip_rdata_i,
    output logic [GROUP_BIT-1:0]                weight_raddr_o,
    input  ising_pkg::j_row_t [PARALLELISM-1:0] weight_i,
    input  ising_pkg::h_t     [PARALLELISM-1:0] hbias_i,
    output logic                                result_valid_o,
    input  logic                                result_ready_i,
    output ising_pkg::energy_res_t              result_o,
    output ising_pkg::spin_t                    best_spin_o,
    output ising_pkg::energy_t                  best_energy_o
);
    import ising_pkg::*;

    logic        fm_req_valid, fm_req_ready;
    spin_req_t   fm_req;
    logic        em_req_valid, em_req_ready;
    spin_req_t   em_req;
    logic        em_res_valid, em_res_ready;
    energy_res_t em_res;
    logic        fm_res_valid, fm_res_ready;
    energy_res_t fm_res;

    flip_manager #(
        .FLIP_ICON_DEPTH            (FLIP_ICON_DEPTH            )
    ) u_flip_manager (
        .clk_i                      (clk_i                      ),
        .rst_n_i                    (rst_n_i                    ),
        .config_valid_i             (config_valid_i             ),
        .config_spin_i              (config_spin_i              ),
        .cmpt_en_i                  (cmpt_en_i                  ),
        .en_comparison_i            (en_comparison_i            ),
        .cmpt_idle_o                (cmpt_idle_o                ),
        .flip_ren_o                 (flip_ren_o                 ),
        .flip_raddr_o               (flip_raddr_o               ),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i ),
        .flip_rdata_i               (flip_rdata_i               ),
        .req_valid_o                (fm_req_valid               ),
        .req_ready_i                (fm_req_ready               ),
        .req_o                      (fm_req                     ),
        .res_valid_i                (fm_res_valid               ),
        .res_ready_o                (fm_res_ready               ),
        .res_i                      (fm_res                     ),
        .result_valid_o             (result_valid_o             ),
        .result_ready_i             (result_ready_i             ),
        .result_o                   (result_o                   ),
        .best_spin_o                (best_spin_o                ),
        .best_energy_o              (best_energy_o              )
    );

    pipe_stage #(.payload_t(spin_req_t)) u_req_stage (
        .clk_i       (clk_i       ),
        .rst_n_i     (rst_n_i     ),
        .in_valid_i  (fm_req_valid),
        .in_ready_o  (fm_req_ready),
        .in_data_i   (fm_req      ),
        .out_valid_o (em_req_valid),
        .out_ready_i (em_req_ready),
        .out_data_o  (em_req      )
    );

    energy_monitor #(.PARALLELISM(PARALLELISM)) u_energy_monitor (
        .clk_i          (clk_i         ),
        .rst_n_i        (rst_n_i       ),
        .spin_valid_i   (em_req_valid  ),
        .spin_ready_o   (em_req_ready  ),
        .spin_i         (em_req        ),
        .weight_raddr_o (weight_raddr_o),
        .weight_i       (weight_i      ),
        .hbias_i        (hbias_i       ),
        .energy_valid_o (em_res_valid  ),
        .energy_ready_i (em_res_ready  ),
        .energy_o       (em_res        )
    );

    pipe_stage #(.payload_t(energy_res_t)) u_res_stage (
        .clk_i       (clk_i       ),
        .rst_n_i     (rst_n_i     ),
        .in_valid_i  (em_res_valid),
        .in_ready_o  (em_res_ready),
        .in_data_i   (em_res      ),
        .out_valid_o (fm_res_valid),
        .out_ready_i (fm_res_ready),
        .out_data_o  (fm_res      )
    );

endmodule

// File: src/energy_monitor.sv
// --------------------------------------------------
// energy monitor
// computes the Ising energy of one candidate spin
// vector, PARALLELISM rows of J and h per cycle,
// from the external weight memory
// --------------------------------------------------
`timescale 1ns/10ps

module energy_monitor #(
    parameter int PARALLELISM = 4,
    localparam int NUM_GROUP  = ising_pkg::NUM_SPIN / PARALLELISM,
    localparam int GROUP_BIT  = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                spin_valid_i,
    output logic                                spin_ready_o,
    input  ising_pkg::spin_req_t                spin_i,
    output logic [GROUP_BIT-1:0]                weight_raddr_o,
    input  ising_pkg::j_row_t [PARALLELISM-1:0] weight_i,
    input  ising_pkg::h_t     [PARALLELISM-1:0] hbias_i,
    output logic                                energy_valid_o,
    input  logic                                energy_ready_i,
    output ising_pkg::energy_res_t              energy_o
);
    import ising_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACC,
        ST_DONE
    } state_e;

    state_e               state_q;
    logic [GROUP_BIT-1:0] grp_q;
    spin_req_t            req_q;
    energy_t              acc_q;
    energy_t              group_sum;

    assign spin_ready_o   = (state_q == ST_IDLE);
    assign energy_valid_o = (state_q == ST_DONE);

    // group g reads rows g*PARALLELISM .. g*PARALLELISM+PARALLELISM-1
    assign weight_raddr_o = grp_q;

    // s_i * (sum_j J[i][j]*s_j + h_i) for every row i of the group
    always_comb begin : p_group_sum
        energy_t                 row_sum;
        energy_t                 row_term;
        logic [SPIN_IDX_BIT-1:0] row;
        group_sum = '0;
        for (int k = 0; k < PARALLELISM; k++) begin
            row     = SPIN_IDX_BIT'(int'(grp_q) * PARALLELISM + k);
            row_sum = '0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                if (req_q.spin[j]) begin
                    row_sum = row_sum + energy_t'(weight_i[k][j]);
                end else begin
                    row_sum = row_sum - energy_t'(weight_i[k][j]);
                end
            end
            row_term = row_sum + energy_t'(hbias_i[k]);
            if (req_q.spin[row]) begin
                group_sum = group_sum + row_term;
            end else begin
                group_sum = group_sum - row_term;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            grp_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (spin_valid_i) begin
                        state_q <= ST_ACC;
                        grp_q   <= '0;
                    end
                end
                ST_ACC: begin
                    if (grp_q == GROUP_BIT'(NUM_GROUP - 1)) begin
                        state_q <= ST_DONE;
                        grp_q   <= '0;
                    end else begin
                        grp_q <= grp_q + 1'b1;
                    end
                end
                ST_DONE: begin
                    if (energy_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // candidate and running sum
    always_ff @(posedge clk_i) begin
        if (spin_valid_i && spin_ready_o) begin
            req_q <= spin_i;
            acc_q <= '0;
        end else if (state_q == ST_ACC) begin
            acc_q <= acc_q + group_sum;
        end
    end

    // accepted is decided by the flip manager
    assign energy_o.spin         = req_q.spin;
    assign energy_o.energy       = acc_q;
    assign energy_o.is_reference = req_q.is_reference;
    assign energy_o.accepted     = 1'b0;

endmodule

// File: src/flip_manager.sv
// --------------------------------------------------
// flip manager
// holds the spin state, applies flip icons to form
// candidates, accepts them greedily on energy and
// reports every evaluated candidate to the host
// --------------------------------------------------
`timescale 1ns/10ps

module flip_manager #(
    parameter int FLIP_ICON_DEPTH = 64,
    localparam int ICON_ADDR_BIT  = $clog2(FLIP_ICON_DEPTH) + 1
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   config_valid_i,
    input  ising_pkg::spin_t       config_spin_i,
    input  logic                   cmpt_en_i,
    input  logic                   en_comparison_i,
    output logic                   cmpt_idle_o,
    output logic                   flip_ren_o,
    output logic [ICON_ADDR_BIT-1:0] flip_raddr_o,
    input  logic [ICON_ADDR_BIT-1:0] icon_last_raddr_plus_one_i,
    input  ising_pkg::spin_t       flip_rdata_i,
    output logic                   req_valid_o,
    input  logic                   req_ready_i,
    output ising_pkg::spin_req_t   req_o,
    input  logic                   res_valid_i,
    output logic                   res_ready_o,
    input  ising_pkg::energy_res_t res_i,
    output logic                   result_valid_o,
    input  logic                   result_ready_i,
    output ising_pkg::energy_res_t result_o,
    output ising_pkg::spin_t       best_spin_o,
    output ising_pkg::energy_t     best_energy_o
);
    import ising_pkg::*;

    // two stages and the monitor hold at most three candidates
    localparam int INFLIGHT_BIT = 3;

    logic                     running_q;
    logic                     ref_pending_q;
    logic                     cmp_en_q;
    logic [ICON_ADDR_BIT-1:0] raddr_q;
    logic [ICON_ADDR_BIT-1:0] icon_end_q;
    logic [INFLIGHT_BIT-1:0]  inflight_q;
    spin_t                    cur_spin_q;
    spin_t                    best_spin_q;
    energy_t                  best_energy_q;

    logic icons_left;
    logic all_issued;
    logic req_fire;
    logic res_fire;
    logic accept;

    assign icons_left = (raddr_q < icon_end_q);
    assign all_issued = !ref_pending_q && !icons_left;

    // greedy mode waits for each result before the next issue
    assign req_valid_o = running_q && (ref_pending_q || icons_left)
                         && (!cmp_en_q || inflight_q == '0);
    assign req_o.spin         = ref_pending_q ? cur_spin_q : (cur_spin_q ^ flip_rdata_i);
    assign req_o.is_reference = ref_pending_q;
    assign req_fire           = req_valid_o && req_ready_i;

    assign flip_ren_o   = req_valid_o && !ref_pending_q;
    assign flip_raddr_o = raddr_q;

    // reference always wins, later candidates only on a strictly lower energy
    assign accept = res_i.is_reference || (cmp_en_q && (res_i.energy < best_energy_q));

    assign result_valid_o = res_valid_i && running_q;
    assign res_ready_o    = result_ready_i && running_q;
    assign res_fire       = result_valid_o && result_ready_i;

    always_comb begin
        result_o          = res_i;
        result_o.accepted = accept;
    end

    assign cmpt_idle_o   = !running_q;
    assign best_spin_o   = best_spin_q;
    assign best_energy_o = best_energy_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            running_q     <= 1'b0;
            ref_pending_q <= 1'b0;
            cmp_en_q      <= 1'b0;
            raddr_q       <= '0;
            icon_end_q    <= '0;
            inflight_q    <= '0;
            cur_spin_q    <= '0;
            best_spin_q   <= '0;
            best_energy_q <= ENERGY_MAX;
        end else if (!running_q) begin
            if (config_valid_i) begin
                cur_spin_q <= config_spin_i;
            end
            if (cmpt_en_i) begin
                running_q     <= 1'b1;
                ref_pending_q <= 1'b1;
                cmp_en_q      <= en_comparison_i;
                raddr_q       <= '0;
                icon_end_q    <= icon_last_raddr_plus_one_i;
            end
        end else begin
            if (req_fire) begin
                if (ref_pending_q) begin
                    ref_pending_q <= 1'b0;
                end else begin
                    raddr_q <= raddr_q + 1'b1;
                end
            end
            if (res_fire && accept) begin
                cur_spin_q    <= res_i.spin;
                best_spin_q   <= res_i.spin;
                best_energy_q <= res_i.energy;
            end
            inflight_q <= inflight_q + INFLIGHT_BIT'(req_fire) - INFLIGHT_BIT'(res_fire);
            // run ends once everything issued has come back
            if (all_issued && inflight_q == '0) begin
                running_q <= 1'b0;
            end
        end
    end

endmodule

// File: src/ising_pkg.sv
// --------------------------------------------------
// ising package
// sizes, spin and energy types, and the payloads
// carried between flip manager and energy monitor
// --------------------------------------------------
package ising_pkg;

    localparam int NUM_SPIN     = 16;
    localparam int BITJ         = 4;
    localparam int BITH         = 4;
    localparam int ENERGY_BIT   = 32;
    localparam int SPIN_IDX_BIT = $clog2(NUM_SPIN);

    // bit value 1 is spin +1, bit value 0 is spin -1
    typedef logic [NUM_SPIN-1:0] spin_t;

    typedef logic signed [ENERGY_BIT-1:0] energy_t;

    typedef logic signed [BITJ-1:0] j_t;
    typedef logic signed [BITH-1:0] h_t;

    // element j of row i holds J[i][j]
    typedef j_t [NUM_SPIN-1:0] j_row_t;

    // largest positive energy, used as best energy before any run
    localparam energy_t ENERGY_MAX = {1'b0, {(ENERGY_BIT-1){1'b1}}};

    typedef struct packed {
        spin_t spin;
        // unflipped evaluation at the start of a run
        logic  is_reference;
    } spin_req_t;

    typedef struct packed {
        spin_t   spin;
        energy_t energy;
        logic    is_reference;
        logic    accepted;
    } energy_res_t;

endpackage

// File: src/pipe_stage.sv
// --------------------------------------------------
// pipe stage
// one-entry valid/ready register slice, full
// throughput, any packed payload type
// --------------------------------------------------
`timescale 1ns/10ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // accept while empty, or while the held entry leaves this cycle
    assign in_ready_o  = !valid_q || out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

// File: tb.f
src/ising_pkg.sv
src/pipe_stage.sv
src/energy_monitor.sv
src/flip_manager.sv
src/digital_macro.sv
verif/digital_macro_properties.sv
verif/tb_digital_macro.sv

// File: verif/digital_macro_properties.sv
// --------------------------------------------------
// digital macro properties
// host result handshake, quiet reset and run end
// checks on the annealer loop
// --------------------------------------------------
`timescale 1ns/10ps

module digital_macro_properties (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   flip_ren_o,
    input logic                   cmpt_idle_o,
    input logic                   result_valid_o,
    input logic                   result_ready_i,
    input ising_pkg::energy_res_t result_o,
    input logic                   res_pending_i
);

    // a stalled result keeps its valid and its data
    a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
        else $error("result_o dropped or changed before its transfer");

    a_reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !flip_ren_o && !result_valid_o)
        else $error("flip read or result active right after reset");

    // the run may not end while the result stage still holds a result
    a_idle_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_pending_i |-> !cmpt_idle_o)
        else $error("cmpt_idle_o high while a result was pending");

endmodule

bind digital_macro digital_macro_properties u_properties (
    .clk_i          (clk_i         ),
    .rst_n_i        (rst_n_i       ),
    .flip_ren_o     (flip_ren_o    ),
    .cmpt_idle_o    (cmpt_idle_o   ),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o      ),
    .res_pending_i  (fm_res_valid  )
);

// File: verif/tb_digital_macro.sv
// --------------------------------------------------
// digital macro testbench
// random J, h and icon memories, a table of runs,
// reference model of energy and greedy acceptance
// --------------------------------------------------
`timescale 1ns/10ps

module tb_digital_macro;
    import ising_pkg::*;

    localparam int PARALLELISM     = 4;
    localparam int FLIP_ICON_DEPTH = 64;
    localparam int NUM_GROUP       = NUM_SPIN / PARALLELISM;
    localparam int GROUP_BIT       = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1;
    localparam int ICON_ADDR_BIT   = $clog2(FLIP_ICON_DEPTH) + 1;
    localparam int NUM_TEST        = 7;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic                     reload;
        spin_t                    load_spin;
        logic                     cmp;
        logic [ICON_ADDR_BIT-1:0] icons;
        logic                     rand_ready;
    } test_t;

    logic clk_i, rst_n_i, config_valid_i, cmpt_en_i, en_comparison_i, cmpt_idle_o;
    logic flip_ren_o, result_valid_o, result_ready_i;
    spin_t config_spin_i, flip_rdata_i, best_spin_o;
    logic [ICON_ADDR_BIT-1:0] flip_raddr_o, icon_last_raddr_plus_one_i;
    logic [GROUP_BIT-1:0] weight_raddr_o;
    j_row_t [PARALLELISM-1:0] weight_i;
    h_t [PARALLELISM-1:0] hbias_i;
    energy_res_t result_o;
    energy_t best_energy_o;

    logic [31:0] lfsr_q = 32'd96008;
    int          j_val[NUM_SPIN][NUM_SPIN];
    int          h_val[NUM_SPIN];
    spin_t       icon_mem[2**ICON_ADDR_BIT];
    test_t       tests[NUM_TEST];
    string       test_name[NUM_TEST];
    string       cur_name = "reset";
    int          num_added = 0;
    int          cycle_count = 0;
    int          cycle_limit = 200;
    logic        rand_ready_q = 1'b0;
    energy_res_t exp_q[$];
    spin_t       model_cur = '0;
    spin_t       model_best_spin = '0;
    energy_t     model_best_energy = ENERGY_MAX;

    digital_macro #(.PARALLELISM(PARALLELISM), .FLIP_ICON_DEPTH(FLIP_ICON_DEPTH)) dut (.*);

    // combinational weight and flip memories
    always_comb begin
        for (int k = 0; k < PARALLELISM; k++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                weight_i[k][j] = j_t'(j_val[int'(weight_raddr_o) * PARALLELISM + k][j]);
            end
            hbias_i[k] = h_t'(h_val[int'(weight_raddr_o) * PARALLELISM + k]);
        end
    end

    // flip data only defined while flip_ren_o is high
    assign flip_rdata_i = flip_ren_o ? icon_mem[flip_raddr_o] : 'x;

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        out;
        v = '0;
        for (int b = 0; b < n; b++) begin
            out    = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (out) begin
                lfsr_q = lfsr_q ^ LFSR_TAPS;
            end
            v = {v[30:0], out};
        end
        return v;
    endfunction

    // full double sum over i and j with the diagonal
    function automatic energy_t ising_energy(input spin_t sp);
        int e;
        int si;
        int sj;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            si = sp[i] ? 1 : -1;
            for (int j = 0; j < NUM_SPIN; j++) begin
                sj = sp[j] ? 1 : -1;
                e  = e + j_val[i][j] * si * sj;
            end
            e = e + h_val[i] * si;
        end
        return energy_t'(e);
    endfunction

    task automatic add_test(input string name, input logic reload, input spin_t sp,
                            input logic cmp, input int icons, input logic rnd);
        test_name[num_added]        = name;
        tests[num_added].reload     = reload;
        tests[num_added].load_spin  = sp;
        tests[num_added].cmp        = cmp;
        tests[num_added].icons      = ICON_ADDR_BIT'(icons);
        tests[num_added].rand_ready = rnd;
        num_added++;
    endtask

    task automatic predict_run(input test_t t);
        spin_t       start;
        energy_res_t r;
        start            = model_cur;
        r.spin           = start;
        r.energy         = ising_energy(start);
        r.is_reference   = 1'b1;
        r.accepted       = 1'b1;
        model_best_spin   = start;
        model_best_energy = r.energy;
        exp_q.push_back(r);
        for (int i = 0; i < int'(t.icons); i++) begin
            r.spin         = (t.cmp ? model_cur : start) ^ icon_mem[i];
            r.energy       = ising_energy(r.spin);
            r.is_reference = 1'b0;
            r.accepted     = t.cmp && (r.energy < model_best_energy);
            if (r.accepted) begin
                model_cur         = r.spin;
                model_best_spin   = r.spin;
                model_best_energy = r.energy;
            end
            exp_q.push_back(r);
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input energy_res_t exp, input energy_res_t act);
        if (exp !== act) begin
            stop_with_failure({$sformatf("ERR %s: expected spin %h energy %0d ref %b acc %b",
                name, exp.spin, exp.energy, exp.is_reference, exp.accepted),
                $sformatf(", actual spin %h energy %0d ref %b acc %b",
                act.spin, act.energy, act.is_reference, act.accepted)});
        end
    endtask

    task automatic check_best(input string name, input spin_t exp_spin, input energy_t exp_energy,
                              input spin_t act_spin, input energy_t act_energy);
        if (exp_spin !== act_spin || exp_energy !== act_energy) begin
            stop_with_failure($sformatf("ERR %s: expected best %h/%0d, actual best %h/%0d",
                name, exp_spin, exp_energy, act_spin, act_energy));
        end
    endtask

    // host ready driven on the falling edge and transfers sampled just after
    initial begin : result_monitor
        logic [31:0] bits;
        forever begin
            @(negedge clk_i);
            bits = rand_ready_q ? lfsr_bits(2) : 32'd3;
            result_ready_i = |bits[1:0];
            #1;
            if (result_valid_o && result_ready_i) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure($sformatf("%s: DUT sent a result that was not expected",
                        cur_name));
                end
                check_result(cur_name, exp_q.pop_front(), result_o);
            end
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk_i);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                stop_with_failure($sformatf("timeout: no finish within %0d cycles", cycle_limit));
            end
        end
    end

    initial begin : main
        logic [31:0] v;
        rst_n_i = 1'b0;
        config_valid_i = 1'b0;
        config_spin_i = '0;
        cmpt_en_i = 1'b0;
        en_comparison_i = 1'b0;
        icon_last_raddr_plus_one_i = '0;
        result_ready_i = 1'b0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            for (int j = 0; j < NUM_SPIN; j++) begin
                v = lfsr_bits(BITJ);
                j_val[i][j] = int'(j_t'(v[BITJ-1:0]));
            end
            v = lfsr_bits(BITH);
            h_val[i] = int'(h_t'(v[BITH-1:0]));
        end
        for (int a = 0; a < 2**ICON_ADDR_BIT; a++) begin
            v = lfsr_bits(NUM_SPIN);
            icon_mem[a] = v[NUM_SPIN-1:0];
        end
        add_test("reset_ref",     1'b0, 16'h0000, 1'b1, 0,  1'b0);
        add_test("no_cmp",        1'b1, 16'h5a3c, 1'b0, 12, 1'b0);
        add_test("greedy",        1'b1, 16'hc3a5, 1'b1, 20, 1'b0);
        add_test("greedy_cont",   1'b0, 16'h0000, 1'b1, 16, 1'b0);
        add_test("rand_no_cmp",   1'b1, 16'h0ff0, 1'b0, 24, 1'b1);
        add_test("rand_greedy",   1'b0, 16'h0000, 1'b1, 64, 1'b1);
        add_test("reload_greedy", 1'b1, 16'hffff, 1'b1, 10, 1'b1);
        for (int t = 0; t < NUM_TEST; t++) begin
            cycle_limit += (int'(tests[t].icons) + 1) * (NUM_GROUP + 4) * 4;
        end
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        if (!cmpt_idle_o || result_valid_o) begin
            stop_with_failure("after reset the DUT is not idle or shows a result");
        end
        check_best("reset", '0, ENERGY_MAX, best_spin_o, best_energy_o);
        for (int t = 0; t < NUM_TEST; t++) begin
            cur_name = test_name[t];
            if (tests[t].reload) begin
                model_cur = tests[t].load_spin;
            end
            predict_run(tests[t]);
            config_valid_i = tests[t].reload;
            config_spin_i = tests[t].load_spin;
            en_comparison_i = tests[t].cmp;
            icon_last_raddr_plus_one_i = tests[t].icons;
            rand_ready_q <= tests[t].rand_ready;
            cmpt_en_i = 1'b1;
            @(negedge clk_i);
            config_valid_i = 1'b0;
            cmpt_en_i = 1'b0;
            while (!cmpt_idle_o) begin
                @(negedge clk_i);
            end
            if (exp_q.size() != 0) begin
                stop_with_failure($sformatf("%s: run ended with %0d results not delivered",
                    cur_name, exp_q.size()));
            end
            check_best(cur_name, model_best_spin, model_best_energy, best_spin_o, best_energy_o);
        end
        $display("No errors");
        $finish;
    end

endmodule
